/* timer_pkg.sv */
// shared widths, register selector encoding and structs for the debug timer unit
`default_nettype none

package timer_pkg;

    // one word covers counts, reloads and register data
    localparam int TIMER_W = 16;

    // upper bound on timers in one unit
    // also the width of per-timer bit fields in register data
    localparam int MAX_TIMERS = 8;

    // register selector, low four address bits
    typedef enum logic [3:0] {
        REG_CTRL   = 4'd0,
        REG_MASK   = 4'd1,
        REG_STATUS = 4'd2,
        REG_RELOAD = 4'd4,
        REG_COUNT  = 4'd5
    } reg_sel_e;

    // decode to timer
    typedef struct packed {
        logic               enable;
        logic [TIMER_W-1:0] reload;
    } timer_cfg_t;

    // timer to status block
    typedef struct packed {
        logic [TIMER_W-1:0] count;
        logic               expired;
    } timer_state_t;

    // decoded read strobe, sampled by the status block
    typedef struct packed {
        logic       valid;
        reg_sel_e   sel;
        logic [3:0] idx;
    } rd_req_t;

endpackage

`default_nettype wire

/* timer_reg_decode.sv */
// register decode for the timer unit; holds enable, mask and reload, forwards reads
`timescale 1ns/10ps
`default_nettype none

module timer_reg_decode #(
    parameter int NUM_TIMERS = 3
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          wr_en,
    input  wire logic                          rd_en,
    input  wire logic [7:0]                    addr,
    input  wire logic [timer_pkg::TIMER_W-1:0] wdata,
    output timer_pkg::timer_cfg_t              cfg [NUM_TIMERS],
    output logic [NUM_TIMERS-1:0]              mask,
    output logic [NUM_TIMERS-1:0]              status_clear,
    output timer_pkg::rd_req_t                 rd_req
);

    import timer_pkg::*;

    logic [3:0]          idx;
    reg_sel_e            sel;

    logic [NUM_TIMERS-1:0] enable_q;
    logic [NUM_TIMERS-1:0] mask_q;
    logic [TIMER_W-1:0]    reload_q [NUM_TIMERS];

    // upper nibble picks the timer, lower nibble the register
    assign idx = addr[7:4];
    assign sel = reg_sel_e'(addr[3:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= '0;
            mask_q   <= '0;
            for (int i = 0; i < NUM_TIMERS; i++) begin
                reload_q[i] <= '0;
            end
        end else if (wr_en) begin
            case (sel)
                // global words, index not looked at
                REG_CTRL: begin
                    enable_q <= wdata[NUM_TIMERS-1:0];
                end
                REG_MASK: begin
                    mask_q <= wdata[NUM_TIMERS-1:0];
                end
                // only an in-range index matches
                REG_RELOAD: begin
                    for (int i = 0; i < NUM_TIMERS; i++) begin
                        if (idx == 4'(i)) begin
                            reload_q[i] <= wdata;
                        end
                    end
                end
                // status handled as a clear pulse, count is read only
                default: begin
                end
            endcase
        end
    end

    // enable bit travels with the reload value
    always_comb begin
        for (int i = 0; i < NUM_TIMERS; i++) begin
            cfg[i].enable = enable_q[i];
            cfg[i].reload = reload_q[i];
        end
    end

    assign mask = mask_q;

    // write-one-to-clear, valid only in the write cycle
    always_comb begin
        status_clear = '0;
        if (wr_en && sel == REG_STATUS) begin
            status_clear = wdata[NUM_TIMERS-1:0];
        end
    end

    always_comb begin
        rd_req.valid = rd_en;
        rd_req.sel   = sel;
        rd_req.idx   = idx;
    end

endmodule

`default_nettype wire

/* debug_timer.sv */
// single up-counter with reload at all ones, held during debug halt
`timescale 1ns/10ps
`default_nettype none

module debug_timer (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  debug_mode,
    input  timer_pkg::timer_cfg_t      cfg,
    output timer_pkg::timer_state_t    state
);

    import timer_pkg::*;

    logic [TIMER_W-1:0] count_q;
    logic               pending_q;
    logic               count_max;
    logic               run;
    logic               do_reload;
    logic               do_inc;

    assign count_max = (count_q == {TIMER_W{1'b1}});
    assign run       = cfg.enable && !debug_mode;

    // a reload owed from the halt takes priority over counting on
    assign do_reload = run && (count_max || pending_q);
    assign do_inc    = run && !count_max && !pending_q;

    // remember a wrap that landed inside the halt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (debug_mode && count_max) begin
            pending_q <= 1'b1;
        end else if (do_reload) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (do_reload) begin
            count_q <= cfg.reload;
        end else if (do_inc) begin
            count_q <= count_q + 1'b1;
        end
    end

    // expiry shows in the reload cycle itself
    always_comb begin
        state.count   = count_q;
        state.expired = do_reload;
    end

endmodule

`default_nettype wire

/* timer_irq_status.sv */
// sticky expiry status, masked interrupt and registered readback for the timer unit
`timescale 1ns/10ps
`default_nettype none

module timer_irq_status #(
    parameter int NUM_TIMERS = 3
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  timer_pkg::timer_state_t            state [NUM_TIMERS],
    input  timer_pkg::timer_cfg_t              cfg [NUM_TIMERS],
    input  wire logic [NUM_TIMERS-1:0]         mask,
    input  wire logic [NUM_TIMERS-1:0]         status_clear,
    input  timer_pkg::rd_req_t                 rd_req,
    output logic [timer_pkg::TIMER_W-1:0]      rdata,
    output logic                               irq
);

    import timer_pkg::*;

    logic [NUM_TIMERS-1:0] status_q;
    logic [NUM_TIMERS-1:0] expired_vec;
    logic [MAX_TIMERS-1:0] en_vec;
    logic [TIMER_W-1:0]    rd_next;

    always_comb begin
        en_vec = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            expired_vec[i] = state[i].expired;
            en_vec[i]      = cfg[i].enable;
        end
    end

    // set wins over a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= '0;
        end else begin
            status_q <= (status_q & ~status_clear) | expired_vec;
        end
    end

    assign irq = |(status_q & mask);

    // index only matters for per-timer registers
    always_comb begin
        rd_next = '0;
        case (rd_req.sel)
            REG_CTRL:   rd_next = TIMER_W'(en_vec);
            REG_MASK:   rd_next = TIMER_W'(MAX_TIMERS'(mask));
            REG_STATUS: rd_next = TIMER_W'(MAX_TIMERS'(status_q));
            REG_RELOAD: begin
                for (int i = 0; i < NUM_TIMERS; i++) begin
                    if (rd_req.idx == 4'(i)) begin
                        rd_next = cfg[i].reload;
                    end
                end
            end
            REG_COUNT: begin
                for (int i = 0; i < NUM_TIMERS; i++) begin
                    if (rd_req.idx == 4'(i)) begin
                        rd_next = state[i].count;
                    end
                end
            end
            default: rd_next = '0;
        endcase
    end

    // holds the last read until the next strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_req.valid) begin
            rdata <= rd_next;
        end
    end

endmodule

`default_nettype wire

/* debug_timer_unit.sv */
// top level of the timer peripheral; register decode, timer bank and status block
`timescale 1ns/10ps
`default_nettype none

module debug_timer_unit #(
    parameter int NUM_TIMERS = 3
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          debug_mode,
    input  wire logic                          wr_en,
    input  wire logic                          rd_en,
    input  wire logic [7:0]                    addr,
    input  wire logic [timer_pkg::TIMER_W-1:0] wdata,
    output logic [timer_pkg::TIMER_W-1:0]      rdata,
    output logic                               irq
);

    import timer_pkg::*;

    timer_cfg_t            cfg [NUM_TIMERS];
    timer_state_t          state [NUM_TIMERS];
    logic [NUM_TIMERS-1:0] mask;
    logic [NUM_TIMERS-1:0] status_clear;
    rd_req_t               rd_req;

    timer_reg_decode #(
        .NUM_TIMERS(NUM_TIMERS)
    ) u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (addr),
        .wdata       (wdata),
        .cfg         (cfg),
        .mask        (mask),
        .status_clear(status_clear),
        .rd_req      (rd_req)
    );

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        debug_timer u_timer (
            .clk       (clk),
            .rst_n     (rst_n),
            .debug_mode(debug_mode),
            .cfg       (cfg[i]),
            .state     (state[i])
        );
    end

    timer_irq_status #(
        .NUM_TIMERS(NUM_TIMERS)
    ) u_status (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .cfg         (cfg),
        .mask        (mask),
        .status_clear(status_clear),
        .rd_req      (rd_req),
        .rdata       (rdata),
        .irq         (irq)
    );

endmodule

`default_nettype wire

/* debug_timer_unit_sva.sv */
// concurrent assertions on timer reload, debug hold, interrupt and readback; bound into the top
`timescale 1ns/10ps
`default_nettype none

module debug_timer_unit_sva #(
    parameter int NUM_TIMERS = 3
) (
    input wire logic                          clk,
    input wire logic                          rst_n,
    input wire logic                          debug_mode,
    input wire timer_pkg::timer_cfg_t         cfg [NUM_TIMERS],
    input wire timer_pkg::timer_state_t       state [NUM_TIMERS],
    input wire logic [NUM_TIMERS-1:0]         mask,
    input wire logic [NUM_TIMERS-1:0]         status,
    input wire logic [timer_pkg::TIMER_W-1:0] rdata,
    input wire logic                          irq
);

    import timer_pkg::*;

    logic [NUM_TIMERS-1:0] expired_vec;

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        assign expired_vec[i] = state[i].expired;

        assert property (@(posedge clk) disable iff (!rst_n)
            state[i].expired |=> state[i].count == $past(cfg[i].reload))
            else $error("timer %0d did not load its reload after expiry", i);

        // halted counters keep their value
        assert property (@(posedge clk) disable iff (!rst_n)
            debug_mode |=> $stable(state[i].count))
            else $error("timer %0d count moved during debug halt", i);
    end

    // a masked bit can only come from an older status bit or a fresh expiry
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(irq) |-> |($past(status | expired_vec) & mask))
        else $error("irq rose without a masked status bit or expiry");

    assert property (@(posedge clk) $rose(rst_n) |-> rdata == '0)
        else $error("rdata not zero after reset");

endmodule

bind debug_timer_unit debug_timer_unit_sva #(
    .NUM_TIMERS(NUM_TIMERS)
) u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .debug_mode(debug_mode),
    .cfg       (cfg),
    .state     (state),
    .mask      (mask),
    .status    (u_status.status_q),
    .rdata     (rdata),
    .irq       (irq)
);

`default_nettype wire

/* debug_timer_unit_tb.sv */
// directed testbench for the debug timer unit, simulated as top with the sources in compile.f
`timescale 1ns/10ps
`default_nettype none

module debug_timer_unit_tb;

    import timer_pkg::*;

    localparam int NUM_TIMERS = 3;
    localparam int CLK_PERIOD = 20;
    localparam int STEP = 7;
    // count and reload test waits out one full wrap from a low count
    localparam int RUN_CYCLES = 200 + 200 + 70100 + 100 + 500 + 500;
    localparam int MARGIN_CYCLES = 2000;

    logic               clk;
    logic               rst_n;
    logic               debug_mode;
    logic               wr_en;
    logic               rd_en;
    logic [7:0]         addr;
    logic [TIMER_W-1:0] wdata;
    logic [TIMER_W-1:0] rdata;
    logic               irq;

    logic [31:0]        lfsr_state;
    int                 value_errors;
    int                 other_errors;
    logic [TIMER_W-1:0] reload_exp [NUM_TIMERS];

    debug_timer_unit #(
        .NUM_TIMERS(NUM_TIMERS)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .debug_mode(debug_mode),
        .wr_en     (wr_en),
        .rd_en     (rd_en),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .irq       (irq)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [TIMER_W-1:0] w);
        w = '0;
        for (int b = 0; b < TIMER_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[TIMER_W-2:0], lfsr_state[31]};
        end
    endtask

    function automatic logic [7:0] reg_addr(input int idx, input reg_sel_e sel);
        return {4'(idx), sel};
    endfunction

    // called on a falling edge, returns on the next one
    task automatic reg_write(input int idx, input reg_sel_e sel, input logic [TIMER_W-1:0] data);
        wr_en = 1'b1;
        addr  = reg_addr(idx, sel);
        wdata = data;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic reg_read(input int idx, input reg_sel_e sel, output logic [TIMER_W-1:0] data);
        rd_en = 1'b1;
        addr  = reg_addr(idx, sel);
        @(negedge clk);
        rd_en = 1'b0;
        data  = rdata;
    endtask

    task automatic check_word(input string name, input logic [TIMER_W-1:0] exp,
                              input logic [TIMER_W-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bits(input string name, input logic [NUM_TIMERS-1:0] exp,
                              input logic [NUM_TIMERS-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_min(input string name, input logic [TIMER_W-1:0] lo,
                             input logic [TIMER_W-1:0] act);
        if ($isunknown(act) || act < lo) begin
            value_errors++;
            $display("FAIL %s: expected at least %h, actual %h", name, lo, act);
        end
    endtask

    task automatic wait_status(input string name, input logic [NUM_TIMERS-1:0] want,
                               input int max_polls);
        logic [TIMER_W-1:0] rd;
        int                 polls;
        rd    = '0;
        polls = 0;
        while ((rd[NUM_TIMERS-1:0] & want) != want && polls < max_polls) begin
            reg_read(0, REG_STATUS, rd);
            polls++;
        end
        if ((rd[NUM_TIMERS-1:0] & want) != want) begin
            other_errors++;
            $display("%s: status bits %b were still not set after %0d reads", name, want, polls);
        end
    endtask

    task automatic reset_values();
        logic [TIMER_W-1:0] rd;
        check_word("reset rdata", '0, rdata);
        check_flag("reset irq", 1'b0, irq);
        // ctrl, mask, status
        for (int s = 0; s < 3; s++) begin
            reg_read(0, reg_sel_e'(s), rd);
            check_word("reset global reg", '0, rd);
        end
        for (int i = 0; i < NUM_TIMERS; i++) begin
            reg_read(i, REG_RELOAD, rd);
            check_word("reset reload", '0, rd);
            reg_read(i, REG_COUNT, rd);
            check_word("reset count", '0, rd);
        end
    endtask

    task automatic register_readback();
        logic [TIMER_W-1:0] rd;
        logic [TIMER_W-1:0] held;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            random_word(reload_exp[i]);
            reg_write(i, REG_RELOAD, reload_exp[i]);
        end
        for (int i = 0; i < NUM_TIMERS; i++) begin
            reg_read(i, REG_RELOAD, rd);
            check_word("reload readback", reload_exp[i], rd);
        end
        reg_write(0, REG_CTRL, 16'h0005);
        reg_read(0, REG_CTRL, rd);
        check_word("ctrl readback", 16'h0005, rd);
        reg_write(0, REG_CTRL, '0);
        reg_write(0, REG_MASK, 16'h0003);
        reg_read(0, REG_MASK, rd);
        check_word("mask readback", 16'h0003, rd);
        reg_write(0, REG_MASK, '0);
        reg_read(0, REG_COUNT, held);
        reg_write(0, REG_COUNT, 16'h1234);
        reg_read(0, REG_COUNT, rd);
        check_word("count write ignored", held, rd);
        // index 3 is past the last timer
        reg_write(3, REG_RELOAD, 16'hA5A5);
        for (int i = 0; i < NUM_TIMERS; i++) begin
            reg_read(i, REG_RELOAD, rd);
            check_word("reload after bad index", reload_exp[i], rd);
        end
        reg_read(3, REG_RELOAD, rd);
        check_word("reload bad index", '0, rd);
        reg_read(3, REG_COUNT, rd);
        check_word("count bad index", '0, rd);
        reg_read(0, reg_sel_e'(4'd3), rd);
        check_word("unknown selector 3", '0, rd);
        reg_read(1, reg_sel_e'(4'hF), rd);
        check_word("unknown selector 15", '0, rd);
    endtask

    task automatic count_and_reload();
        logic [TIMER_W-1:0] first;
        logic [TIMER_W-1:0] second;
        logic [TIMER_W-1:0] rd;
        reload_exp[0] = 16'hFFF0;
        reload_exp[1] = 16'hFF00;
        reg_write(0, REG_RELOAD, reload_exp[0]);
        reg_write(1, REG_RELOAD, reload_exp[1]);
        reg_write(0, REG_CTRL, 16'h0003);
        reg_read(0, REG_COUNT, first);
        repeat (STEP - 1) @(negedge clk);
        reg_read(0, REG_COUNT, second);
        check_word("count step", first + TIMER_W'(STEP), second);
        wait_status("first wrap", 3'b011, 70000);
        reg_read(0, REG_COUNT, rd);
        check_min("timer 0 after wrap", reload_exp[0], rd);
        reg_read(1, REG_COUNT, rd);
        check_min("timer 1 after wrap", reload_exp[1], rd);
        reg_read(0, REG_STATUS, rd);
        check_bits("status after wrap", 3'b011, rd[NUM_TIMERS-1:0]);
    endtask

    task automatic debug_halt();
        logic [TIMER_W-1:0] held;
        logic [TIMER_W-1:0] rd;
        int                 to_max;
        reg_write(0, REG_CTRL, 16'h0001);
        debug_mode = 1'b1;
        reg_write(0, REG_STATUS, 16'h0007);
        reg_read(0, REG_COUNT, held);
        repeat (5) @(negedge clk);
        reg_read(0, REG_COUNT, rd);
        check_word("halt count stable", held, rd);
        reg_read(0, REG_STATUS, rd);
        check_bits("halt status", '0, rd[NUM_TIMERS-1:0]);
        // let it run until the next edge would see all ones, then halt again
        to_max = int'(16'hFFFF - held);
        debug_mode = 1'b0;
        repeat (to_max) @(negedge clk);
        debug_mode = 1'b1;
        repeat (2) @(negedge clk);
        reg_read(0, REG_COUNT, rd);
        check_word("held at all ones", 16'hFFFF, rd);
        repeat (4) @(negedge clk);
        reg_read(0, REG_COUNT, rd);
        check_word("still at all ones", 16'hFFFF, rd);
        reg_read(0, REG_STATUS, rd);
        check_bits("no expiry in halt", '0, rd[NUM_TIMERS-1:0]);
        debug_mode = 1'b0;
        @(negedge clk);
        reg_read(0, REG_COUNT, rd);
        check_word("restart from reload", reload_exp[0], rd);
        reg_read(0, REG_STATUS, rd);
        check_bits("expiry after halt", 3'b001, rd[NUM_TIMERS-1:0]);
    endtask

    task automatic irq_and_clear();
        logic [TIMER_W-1:0]    rd;
        logic [NUM_TIMERS-1:0] status_exp;
        logic [NUM_TIMERS-1:0] mask_exp;
        reg_write(0, REG_CTRL, 16'h0003);
        wait_status("status for irq", 3'b011, 400);
        reg_write(0, REG_CTRL, '0);
        status_exp = 3'b011;
        mask_exp   = 3'b000;
        check_flag("irq all masked off", |(status_exp & mask_exp), irq);
        mask_exp = 3'b010;
        reg_write(0, REG_MASK, TIMER_W'(mask_exp));
        check_flag("irq mask bit 1", |(status_exp & mask_exp), irq);
        status_exp = 3'b001;
        reg_write(0, REG_STATUS, 16'h0002);
        check_flag("irq after clear bit 1", |(status_exp & mask_exp), irq);
        reg_read(0, REG_STATUS, rd);
        check_bits("only bit 1 cleared", status_exp, rd[NUM_TIMERS-1:0]);
        mask_exp = 3'b001;
        reg_write(0, REG_MASK, TIMER_W'(mask_exp));
        check_flag("irq mask bit 0", |(status_exp & mask_exp), irq);
        status_exp = 3'b000;
        reg_write(0, REG_STATUS, 16'h0001);
        check_flag("irq after clear bit 0", |(status_exp & mask_exp), irq);
        reg_read(0, REG_STATUS, rd);
        check_bits("status all clear", status_exp, rd[NUM_TIMERS-1:0]);
    endtask

    task automatic timer_independence();
        logic [TIMER_W-1:0] rd;
        logic [TIMER_W-1:0] idle1;
        logic [TIMER_W-1:0] idle2;
        reg_write(0, REG_STATUS, 16'h0007);
        reg_read(2, REG_COUNT, idle2);
        reg_write(0, REG_CTRL, 16'h0001);
        reg_read(1, REG_COUNT, idle1);
        wait_status("timer 0 alone", 3'b001, 40);
        reg_read(0, REG_STATUS, rd);
        check_bits("only timer 0 expired", 3'b001, rd[NUM_TIMERS-1:0]);
        reg_read(0, REG_COUNT, rd);
        check_min("timer 0 range", reload_exp[0], rd);
        reg_read(1, REG_COUNT, rd);
        check_word("disabled timer 1 constant", idle1, rd);
        reg_write(0, REG_CTRL, 16'h0002);
        reg_write(0, REG_STATUS, 16'h0007);
        wait_status("timer 1 alone", 3'b010, 300);
        reg_read(0, REG_STATUS, rd);
        check_bits("only timer 1 expired", 3'b010, rd[NUM_TIMERS-1:0]);
        reg_read(1, REG_COUNT, rd);
        check_min("timer 1 range", reload_exp[1], rd);
        reg_read(2, REG_COUNT, rd);
        check_word("disabled timer 2 constant", idle2, rd);
        reg_write(0, REG_CTRL, '0);
    endtask

    initial begin
        #(CLK_PERIOD * (RUN_CYCLES + MARGIN_CYCLES));
        $display("timeout: tests did not finish within %0d cycles", RUN_CYCLES + MARGIN_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        debug_mode   = 1'b0;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        addr         = '0;
        wdata        = '0;
        lfsr_state   = 32'd90565;
        value_errors = 0;
        other_errors = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        reset_values();
        register_readback();
        count_and_reload();
        debug_halt();
        irq_and_clear();
        timer_independence();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
timer_pkg.sv
timer_reg_decode.sv
debug_timer.sv
timer_irq_status.sv
debug_timer_unit.sv
debug_timer_unit_sva.sv
debug_timer_unit_tb.sv

/* Bender.yml */
package:
  name: debug_timer_unit

sources:
  - timer_pkg.sv
  - timer_reg_decode.sv
  - debug_timer.sv
  - timer_irq_status.sv
  - debug_timer_unit.sv
  - target: test
    files:
      - debug_timer_unit_sva.sv
      - debug_timer_unit_tb.sv
